// ==== hdl/rob_pkg.sv ====
// shared sizes for the ROB; lane and port counts are fixed here and the RTL is not generic in them
package rob_pkg;

    // storage
    localparam int ROB_DEPTH = 16;  // entries
    localparam int TAG_W     = 4;   // entry index, wraps at ROB_DEPTH
    localparam int CNT_W     = 5;   // occupancy, must reach ROB_DEPTH itself

    // lanes and ports
    localparam int RET_W     = 2;   // retire lanes per cycle
    localparam int WB_W      = 2;   // write-back ports
    localparam int RCNT_W    = 2;   // retire count, holds 0 to RET_W

    // datapath
    localparam int XLEN      = 32;  // pc width
    localparam int IR_W      = 32;  // instruction word
    localparam int CAUSE_W   = 5;   // exception cause

    // the one instruction word the retire stage looks for
    localparam logic [IR_W-1:0] FENCE_I_IR = 32'h0000100f;

endpackage

// ==== hdl/rob_payload_ram.sv ====
// pc and instruction storage; no reset, contents are only meaningful where the status bits say busy
`timescale 1ns/1ps

module rob_payload_ram import rob_pkg::*; (
    input  logic                             clk,
    input  logic                             alloc_en,   // dispatch write
    input  logic [TAG_W-1:0]                 alloc_idx,  // tail entry
    input  logic [XLEN-1:0]                  alloc_pc,
    input  logic [IR_W-1:0]                  alloc_ir,
    input  logic [RET_W-1:0][TAG_W-1:0]      rd_idx,     // head, head+1
    output logic [RET_W-1:0][XLEN-1:0]       rd_pc,
    output logic [RET_W-1:0][IR_W-1:0]       rd_ir
);

    logic [XLEN-1:0] pc_mem [ROB_DEPTH];
    logic [IR_W-1:0] ir_mem [ROB_DEPTH];

    // single write port, dispatch only
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            pc_mem[alloc_idx] <= alloc_pc;
            ir_mem[alloc_idx] <= alloc_ir;
        end
    end

    // asynchronous reads for the retire lanes
    always_comb begin
        for (int i = 0; i < RET_W; i++) begin
            rd_pc[i] = pc_mem[rd_idx[i]];
            rd_ir[i] = ir_mem[rd_idx[i]];
        end
    end

endmodule

// ==== hdl/rob_status.sv ====
// per-entry status; write-backs to entries that are not busy are dropped, ports must not share a tag
`timescale 1ns/1ps

module rob_status import rob_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc_en,
    input  logic [TAG_W-1:0]              alloc_idx,
    input  logic [WB_W-1:0]               wb_valid,
    input  logic [WB_W-1:0][TAG_W-1:0]    wb_tag,
    input  logic [WB_W-1:0]               wb_exc,
    input  logic [WB_W-1:0][CAUSE_W-1:0]  wb_cause,
    input  logic                          flush,
    input  logic [RCNT_W-1:0]             retire_cnt,
    input  logic [TAG_W-1:0]              head,
    output logic [RET_W-1:0]              head_busy,   // head, head+1
    output logic [RET_W-1:0]              head_done,
    output logic [RET_W-1:0]              head_exc,
    output logic [CAUSE_W-1:0]            head_cause   // head entry only
);

    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] exc;
    logic [CAUSE_W-1:0]   cause [ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
            done <= '0;
            exc  <= '0;
        end else begin
            // retired entries leave first, tail never overlaps them
            for (int i = 0; i < RET_W; i++) begin
                if (RCNT_W'(i) < retire_cnt)
                    busy[head + TAG_W'(i)] <= 1'b0;
            end
            if (alloc_en) begin
                busy[alloc_idx] <= 1'b1;
                done[alloc_idx] <= 1'b0;
                exc[alloc_idx]  <= 1'b0;
            end
            for (int k = 0; k < WB_W; k++) begin
                if (wb_valid[k] && busy[wb_tag[k]]) begin
                    done[wb_tag[k]] <= 1'b1;
                    exc[wb_tag[k]]  <= wb_exc[k];
                end
            end
        end
    end

    // cause is payload, qualified by exc
    always_ff @(posedge clk) begin
        for (int k = 0; k < WB_W; k++) begin
            if (wb_valid[k] && busy[wb_tag[k]])
                cause[wb_tag[k]] <= wb_cause[k];
        end
    end

    always_comb begin
        logic [TAG_W-1:0] idx;
        for (int i = 0; i < RET_W; i++) begin
            idx          = head + TAG_W'(i);
            head_busy[i] = busy[idx];
            head_done[i] = done[idx];
            head_exc[i]  = exc[idx];
        end
        head_cause = cause[head];
    end

endmodule

// ==== hdl/rob_alloc.sv ====
// pointer and count keeper; dispatch is refused while full, during flush and until reset has ended
`timescale 1ns/1ps

module rob_alloc import rob_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid,
    input  logic [RCNT_W-1:0]  retire_cnt,
    input  logic               flush,
    output logic               disp_ready,
    output logic [TAG_W-1:0]   disp_tag,    // tail, valid with the handshake
    output logic               alloc_en,
    output logic [TAG_W-1:0]   head,
    output logic [CNT_W-1:0]   count
);

    logic [TAG_W-1:0] tail;
    logic             alloc_on;  // low through reset, high one cycle later

    always_ff @(posedge clk) begin
        if (rst)
            alloc_on <= 1'b0;
        else
            alloc_on <= 1'b1;
    end

    assign disp_ready = alloc_on && (count != CNT_W'(ROB_DEPTH)) && !flush;
    assign alloc_en   = disp_valid && disp_ready;
    assign disp_tag   = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else begin
            head <= head + TAG_W'(retire_cnt);  // zero in the flush cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            tail  <= head;  // empty again, head holds still
            count <= '0;
        end else begin
            if (alloc_en)
                tail <= tail + TAG_W'(1);
            count <= count + CNT_W'(alloc_en) - CNT_W'(retire_cnt);
        end
    end

endmodule

// ==== hdl/rob_retire.sv ====
// combinational retire select; only the head entry can raise an exception, lanes retire strictly in order
`timescale 1ns/1ps

module rob_retire import rob_pkg::*; (
    input  logic [RET_W-1:0]             head_busy,
    input  logic [RET_W-1:0]             head_done,
    input  logic [RET_W-1:0]             head_exc,
    input  logic [CAUSE_W-1:0]           head_cause,
    input  logic [RET_W-1:0][XLEN-1:0]   rd_pc,
    input  logic [RET_W-1:0][IR_W-1:0]   rd_ir,
    output logic [RET_W-1:0]             ret_valid,
    output logic [RET_W-1:0][XLEN-1:0]   ret_pc,
    output logic [RET_W-1:0][IR_W-1:0]   ret_ir,
    output logic [RCNT_W-1:0]            retire_cnt,
    output logic                         exc_valid,
    output logic [XLEN-1:0]              exc_pc,
    output logic [CAUSE_W-1:0]           exc_cause,
    output logic                         flush,
    output logic                         fence_i
);

    logic [RET_W-1:0] lane_ok;  // finished cleanly

    always_comb begin
        for (int i = 0; i < RET_W; i++)
            lane_ok[i] = head_busy[i] && head_done[i] && !head_exc[i];
    end

    // a faulting head blocks every lane
    assign exc_valid = head_busy[0] && head_done[0] && head_exc[0];
    assign flush     = exc_valid;

    always_comb begin
        exc_pc    = '0;
        exc_cause = '0;
        if (exc_valid) begin
            exc_pc    = rd_pc[0];
            exc_cause = head_cause;
        end
    end

    // in-order chain, lane i needs every older lane
    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int i = 0; i < RET_W; i++) begin
            chain        = chain && lane_ok[i];
            ret_valid[i] = chain;
        end
    end

    always_comb begin
        retire_cnt = '0;
        for (int i = 0; i < RET_W; i++) begin
            if (ret_valid[i])
                retire_cnt = retire_cnt + RCNT_W'(1);
        end
    end

    // zero the payload on idle lanes
    always_comb begin
        for (int i = 0; i < RET_W; i++) begin
            ret_pc[i] = ret_valid[i] ? rd_pc[i] : '0;
            ret_ir[i] = ret_valid[i] ? rd_ir[i] : '0;
        end
    end

    always_comb begin
        fence_i = 1'b0;
        for (int i = 0; i < RET_W; i++) begin
            if (ret_valid[i] && rd_ir[i] == FENCE_I_IR)
                fence_i = 1'b1;
        end
    end

endmodule

// ==== hdl/rob_top.sv ====
// reorder buffer top; one dispatch port, write-back ports have no ready and must not repeat a tag
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    // dispatch
    input  logic                          disp_valid,
    input  logic [XLEN-1:0]               disp_pc,
    input  logic [IR_W-1:0]               disp_ir,
    output logic                          disp_ready,
    output logic [TAG_W-1:0]              disp_tag,
    // write-back
    input  logic [WB_W-1:0]               wb_valid,
    input  logic [WB_W-1:0][TAG_W-1:0]    wb_tag,
    input  logic [WB_W-1:0]               wb_exc,
    input  logic [WB_W-1:0][CAUSE_W-1:0]  wb_cause,
    // retirement
    output logic [RET_W-1:0]              ret_valid,
    output logic [RET_W-1:0][XLEN-1:0]    ret_pc,
    output logic [RET_W-1:0][IR_W-1:0]    ret_ir,
    output logic                          exc_valid,
    output logic [XLEN-1:0]               exc_pc,
    output logic [CAUSE_W-1:0]            exc_cause,
    output logic                          fence_i
);

    logic                         alloc_en;
    logic [TAG_W-1:0]             head;
    logic [CNT_W-1:0]             count;      // occupancy, watched by the bound checks
    logic [RCNT_W-1:0]            retire_cnt;
    logic                         flush;
    logic [RET_W-1:0][TAG_W-1:0]  rd_idx;
    logic [RET_W-1:0][XLEN-1:0]   rd_pc;
    logic [RET_W-1:0][IR_W-1:0]   rd_ir;
    logic [RET_W-1:0]             head_busy;
    logic [RET_W-1:0]             head_done;
    logic [RET_W-1:0]             head_exc;
    logic [CAUSE_W-1:0]           head_cause;

    // head side read ports
    always_comb begin
        for (int i = 0; i < RET_W; i++)
            rd_idx[i] = head + TAG_W'(i);
    end

    rob_alloc alloc0 (
        .clk(clk), .rst(rst), .disp_valid(disp_valid), .retire_cnt(retire_cnt),
        .flush(flush), .disp_ready(disp_ready), .disp_tag(disp_tag),
        .alloc_en(alloc_en), .head(head), .count(count)
    );

    rob_payload_ram ram0 (
        .clk(clk), .alloc_en(alloc_en), .alloc_idx(disp_tag), .alloc_pc(disp_pc),
        .alloc_ir(disp_ir), .rd_idx(rd_idx), .rd_pc(rd_pc), .rd_ir(rd_ir)
    );

    rob_status status0 (
        .clk(clk), .rst(rst), .alloc_en(alloc_en), .alloc_idx(disp_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_exc(wb_exc), .wb_cause(wb_cause),
        .flush(flush), .retire_cnt(retire_cnt), .head(head),
        .head_busy(head_busy), .head_done(head_done), .head_exc(head_exc),
        .head_cause(head_cause)
    );

    rob_retire retire0 (
        .head_busy(head_busy), .head_done(head_done), .head_exc(head_exc),
        .head_cause(head_cause), .rd_pc(rd_pc), .rd_ir(rd_ir),
        .ret_valid(ret_valid), .ret_pc(ret_pc), .ret_ir(ret_ir),
        .retire_cnt(retire_cnt), .exc_valid(exc_valid), .exc_pc(exc_pc),
        .exc_cause(exc_cause), .flush(flush), .fence_i(fence_i)
    );

endmodule

// ==== bench/rob_properties.sv ====
// boundary checks for the ROB top, bound to every rob_top instance; two retire lanes assumed
`timescale 1ns/1ps

module rob_properties import rob_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              disp_ready,
    input logic              exc_valid,
    input logic [RET_W-1:0]  ret_valid,
    input logic [CNT_W-1:0]  count
);

    int fail_count;  // failed assertions so far

    // a faulting head blocks both lanes
    exc_blocks_retire: assert property (
        @(posedge clk) disable iff (rst) exc_valid |-> (ret_valid == '0)
    ) else begin
        fail_count++;
        $error("exception reported in a cycle where a lane retires");
    end

    lane_order: assert property (
        @(posedge clk) disable iff (rst) ret_valid[1] |-> ret_valid[0]
    ) else begin
        fail_count++;
        $error("lane 1 retired without lane 0");
    end

    reset_blocks_dispatch: assert property (
        @(posedge clk) rst |=> !disp_ready
    ) else begin
        fail_count++;
        $error("dispatch ready in the cycle after reset");
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (rst) count <= CNT_W'(ROB_DEPTH)
    ) else begin
        fail_count++;
        $error("occupancy count above the buffer depth");
    end

endmodule

bind rob_top rob_properties props0 (
    .clk(clk), .rst(rst), .disp_ready(disp_ready),
    .exc_valid(exc_valid), .ret_valid(ret_valid), .count(count)
);

// ==== bench/rob_tb.sv ====
// ROB testbench; reads bench/rob_tests.txt from the project root, expects two write-back ports and two lanes
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

    logic                          clk;
    logic                          rst;
    logic                          disp_valid;
    logic [XLEN-1:0]               disp_pc;
    logic [IR_W-1:0]               disp_ir;
    logic                          disp_ready;
    logic [TAG_W-1:0]              disp_tag;
    logic [WB_W-1:0]               wb_valid;
    logic [WB_W-1:0][TAG_W-1:0]    wb_tag;
    logic [WB_W-1:0]               wb_exc;
    logic [WB_W-1:0][CAUSE_W-1:0]  wb_cause;
    logic [RET_W-1:0]              ret_valid;
    logic [RET_W-1:0][XLEN-1:0]    ret_pc;
    logic [RET_W-1:0][IR_W-1:0]    ret_ir;
    logic                          exc_valid;
    logic [XLEN-1:0]               exc_pc;
    logic [CAUSE_W-1:0]            exc_cause;
    logic                          fence_i;

    // one entry per line of the data file
    logic [XLEN-1:0]     t_pc[$];
    logic [IR_W-1:0]     t_ir[$];
    bit                  t_exc[$];
    logic [CAUSE_W-1:0]  t_cause[$];
    int                  t_delay[$];

    // per operation bookkeeping, same index as the tests
    logic [TAG_W-1:0]    acc_tag[$];
    int                  wb_due[$];   // earliest write-back cycle
    int                  wb_at[$];    // cycle the write-back was driven
    bit                  wb_sent[$];

    int                  mq[$];       // accepted, oldest first
    int                  n_tests;
    int                  nd;          // next operation to offer
    bit                  gap_pending; // idle dispatch cycle before nd
    bit                  loaded;
    logic [TAG_W-1:0]    head_model;
    logic [TAG_W-1:0]    tail_model;
    logic [31:0]         lfsr_state;
    int                  errors;
    int                  checks;
    int                  accepted;
    int                  retired;
    int                  dut_retired; // lanes the DUT reported
    int                  flushed;
    int                  two_lane;
    int                  fences;
    int                  excs;
    int                  full_cycles;

    rob_top dut0 (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_pc(disp_pc), .disp_ir(disp_ir),
        .disp_ready(disp_ready), .disp_tag(disp_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_exc(wb_exc), .wb_cause(wb_cause),
        .ret_valid(ret_valid), .ret_pc(ret_pc), .ret_ir(ret_ir),
        .exc_valid(exc_valid), .exc_pc(exc_pc), .exc_cause(exc_cause), .fence_i(fence_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // taps 32, 22, 2, 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    // done is visible one edge after the write-back was driven
    function automatic logic entry_done(input int idx, input int cyc);
        return wb_sent[idx] && (wb_at[idx] < cyc);
    endfunction

    task automatic load_tests();
        int          fd;
        int          n_read;
        string       line;
        logic [31:0] f_pc;
        logic [31:0] f_ir;
        int          f_exc;
        int          f_cause;
        int          f_delay;
        fd = $fopen("bench/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/rob_tests.txt, there is nothing to run");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n_read = $sscanf(line, "%h %h %d %d %d", f_pc, f_ir, f_exc, f_cause, f_delay);
                    if (n_read == 5) begin
                        t_pc.push_back(f_pc);
                        t_ir.push_back(f_ir);
                        t_exc.push_back(f_exc != 0);
                        t_cause.push_back(CAUSE_W'(f_cause));
                        t_delay.push_back(f_delay);
                        acc_tag.push_back('0);
                        wb_due.push_back(0);
                        wb_at.push_back(0);
                        wb_sent.push_back(1'b0);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = t_pc.size();
    endtask

    task automatic drive_inputs(input int cyc);
        int due[$];
        int port;
        int idx;
        wb_valid   = '0;
        wb_tag     = '0;
        wb_exc     = '0;
        wb_cause   = '0;
        disp_valid = 1'b0;
        if (nd < n_tests) begin
            if (gap_pending) begin
                gap_pending = 1'b0;  // one idle cycle
            end else begin
                disp_valid = 1'b1;
                disp_pc    = t_pc[nd];
                disp_ir    = t_ir[nd];
            end
        end
        foreach (mq[j]) begin
            if (!wb_sent[mq[j]] && wb_due[mq[j]] <= cyc && due.size() < WB_W)
                due.push_back(mq[j]);
        end
        if (due.size() > 0) begin
            port = int'(next_rand_bit());
            for (int j = 0; j < due.size(); j++) begin
                idx            = due[j];
                wb_valid[port] = 1'b1;
                wb_tag[port]   = acc_tag[idx];
                wb_exc[port]   = t_exc[idx];
                wb_cause[port] = t_cause[idx];
                wb_sent[idx]   = 1'b1;
                wb_at[idx]     = cyc;
                port           = 1 - port;  // second one takes the other port
            end
        end
    endtask

    task automatic sample_outputs(input int cyc);
        int   f;
        int   s;
        logic e_ret0;
        logic e_ret1;
        logic e_exc;
        logic e_fence;
        logic e_ready;
        f      = -1;
        s      = -1;
        e_ret0 = 1'b0;
        e_ret1 = 1'b0;
        e_exc  = 1'b0;
        if (mq.size() > 0) begin
            f = mq[0];
            if (entry_done(f, cyc)) begin
                e_exc  = t_exc[f];
                e_ret0 = !t_exc[f];
            end
        end
        if (e_ret0 && mq.size() > 1) begin
            s      = mq[1];
            e_ret1 = entry_done(s, cyc) && !t_exc[s];
        end
        e_fence = (e_ret0 && t_ir[f] == FENCE_I_IR) || (e_ret1 && t_ir[s] == FENCE_I_IR);
        e_ready = (mq.size() < ROB_DEPTH) && !e_exc;

        check_eq(64'(ret_valid[0]), 64'(e_ret0), "lane 0 retire");
        check_eq(64'(ret_valid[1]), 64'(e_ret1), "lane 1 retire");
        if (e_ret0) begin
            check_eq(64'(ret_pc[0]), 64'(t_pc[f]), "lane 0 pc");
            check_eq(64'(ret_ir[0]), 64'(t_ir[f]), "lane 0 instruction");
        end
        if (e_ret1) begin
            check_eq(64'(ret_pc[1]), 64'(t_pc[s]), "lane 1 pc");
            check_eq(64'(ret_ir[1]), 64'(t_ir[s]), "lane 1 instruction");
        end
        check_eq(64'(exc_valid), 64'(e_exc), "exception valid");
        if (e_exc) begin
            check_eq(64'(exc_pc), 64'(t_pc[f]), "exception pc");
            check_eq(64'(exc_cause), 64'(t_cause[f]), "exception cause");
        end
        check_eq(64'(fence_i), 64'(e_fence), "fence.i flag");
        check_eq(64'(disp_ready), 64'(e_ready), "dispatch ready");

        for (int i = 0; i < RET_W; i++) begin
            if (ret_valid[i] === 1'b1)
                dut_retired++;
        end
        if (e_ret1)
            two_lane++;
        if (e_fence)
            fences++;
        if (mq.size() == ROB_DEPTH && disp_valid)
            full_cycles++;  // source held off

        // everything younger than the faulting entry is gone
        if (e_exc) begin
            excs++;
            flushed   += mq.size();
            mq.delete();
            tail_model = head_model;
        end else begin
            if (e_ret0) begin
                void'(mq.pop_front());
                retired++;
                head_model = head_model + TAG_W'(1);
            end
            if (e_ret1) begin
                void'(mq.pop_front());
                retired++;
                head_model = head_model + TAG_W'(1);
            end
        end

        if (disp_valid && disp_ready) begin
            check_eq(64'(disp_tag), 64'(tail_model), "dispatch tag");
            acc_tag[nd] = tail_model;
            wb_due[nd]  = cyc + 1 + t_delay[nd];
            mq.push_back(nd);
            tail_model  = tail_model + TAG_W'(1);
            accepted++;
            nd++;
            if (nd < n_tests)
                gap_pending = next_rand_bit();
        end
    endtask

    initial begin : main
        int cyc;
        rst         = 1'b1;
        disp_valid  = 1'b0;
        disp_pc     = '0;
        disp_ir     = '0;
        wb_valid    = '0;
        wb_tag      = '0;
        wb_exc      = '0;
        wb_cause    = '0;
        lfsr_state  = 32'h71c1;
        gap_pending = 1'b0;
        head_model  = '0;
        tail_model  = '0;
        load_tests();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        @(posedge clk);  // dispatch opens one edge after reset
        cyc = 0;
        while (nd < n_tests || mq.size() > 0) begin
            #2;
            drive_inputs(cyc);
            @(negedge clk);
            sample_outputs(cyc);
            @(posedge clk);
            cyc++;
        end
        @(negedge clk);  // last edge's assertions have run

        check_eq(64'(dut_retired + flushed), 64'(accepted), "retired plus flushed operations");
        if (two_lane == 0) begin
            $display("no cycle retired two entries at once");
            errors++;
        end
        if (full_cycles == 0) begin
            $display("the buffer never filled up far enough to hold dispatch off");
            errors++;
        end
        if (fences == 0 || excs == 0) begin
            $display("the run retired no fence.i or raised no exception");
            errors++;
        end
        if (dut0.props0.fail_count != 0) begin
            $display("bound assertions on the top level failed %0d times",
                     dut0.props0.fail_count);
            errors += dut0.props0.fail_count;
        end
        $display("checks: %0d, errors: %0d, retired: %0d, flushed: %0d, two-lane cycles: %0d",
                 checks, errors, retired, flushed, two_lane);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = 40 * n_tests + 100;  // cycles
        #(limit * 20);
        $display("the run timed out after %0d cycles with operations still in flight", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/rob_tests.txt ====
# one dispatched operation per line, in dispatch order
# pc(hex) instruction(hex) exception(0/1) cause(dec) write-back delay(cycles, dec)
# long head entry so that more than 16 operations wait behind it
00001000 00000013 0 0 40
00001004 00100093 0 0 1
00001008 00200113 0 0 3
0000100c 00308193 0 0 2
00001010 00410213 0 0 5
00001014 00518293 0 0 1
00001018 00620313 0 0 4
0000101c 00728393 0 0 2
00001020 00830413 0 0 2
00001024 00938493 0 0 7
00001028 00a40513 0 0 1
0000102c 00b48593 0 0 3
00001030 00c50613 0 0 2
00001034 00d58693 0 0 6
00001038 00e60713 0 0 1
0000103c 00f68793 0 0 2
00001040 01070813 0 0 3
00001044 01178893 0 0 1
# fence.i, then a word that differs from it in one field
00001048 0000100f 0 0 2
0000104c 0000200f 0 0 2
# faulting entry, the two after it finish first and are flushed
00001050 00000073 1 11 9
00001054 00100113 0 0 1
00001058 00200193 0 0 2
00002000 00000013 0 0 3
00002004 00000013 0 0 3
00002008 ffffffff 1 2 0
0000200c 0000100f 0 0 0

// ==== all.f ====
hdl/rob_pkg.sv
hdl/rob_payload_ram.sv
hdl/rob_status.sv
hdl/rob_alloc.sv
hdl/rob_retire.sv
hdl/rob_top.sv
bench/rob_properties.sv
bench/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ROB testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rob_tb -f all.f -o rob_sim
obj_dir/rob_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
